//--- include/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// widths
`define CSR_NUM_W   14
`define CSR_DATA_W  32

// implemented CSR numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// bits that software may change
`define CSR_WMASK_CRMD    32'h0000_01ff
`define CSR_WMASK_PRMD    32'h0000_0007
`define CSR_WMASK_ECFG    32'h0000_1bff
`define CSR_WMASK_ESTAT   32'h0000_0003
`define CSR_WMASK_EENTRY  32'hffff_ffc0
`define CSR_WMASK_TCFG    32'hffff_ffff
`define CSR_WMASK_FULL    32'hffff_ffff

// reset images, DA set in CRMD
`define CSR_CRMD_RST    32'h0000_0008
`define CSR_EENTRY_RST  32'h1c00_8000

// exception codes that record a bad address
`define CSR_ECODE_ADE  6'd8
`define CSR_ECODE_ALE  6'd9

// bit positions
`define CSR_CRMD_IE_BIT        2
`define CSR_TIMER_IRQ_BIT      11
`define CSR_TCFG_EN_BIT        0
`define CSR_TCFG_PERIODIC_BIT  1

`endif

//--- hdl/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

    // masked write request from the pipeline
    typedef struct packed {
        logic                   we;
        logic [`CSR_DATA_W-1:0] mask;
        logic [`CSR_DATA_W-1:0] value;
    } csr_wr_t;

    // one bit per implemented register
    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ecfg;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
        logic       tid;
        logic       tcfg;
        logic       tval;
        logic       ticlr;
    } csr_sel_t;

    // exception report from writeback
    typedef struct packed {
        logic                   valid;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } csr_exc_t;

    // ESTAT only keeps the fields owned by the trap block
    typedef struct packed {
        logic [`CSR_DATA_W-1:0]      crmd;
        logic [`CSR_DATA_W-1:0]      prmd;
        logic [`CSR_DATA_W-1:0]      ecfg;
        logic [1:0]                  estat_is;
        logic [5:0]                  estat_ecode;
        logic [8:0]                  estat_esubcode;
        logic [`CSR_DATA_W-1:0]      era;
        logic [`CSR_DATA_W-1:0]      badv;
        logic [`CSR_DATA_W-1:0]      eentry;
        logic [3:0][`CSR_DATA_W-1:0] save;
        logic [`CSR_DATA_W-1:0]      tid;
    } csr_trap_state_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tcfg;
        logic [`CSR_DATA_W-1:0] tval;
        logic                   ti;
    } csr_timer_state_t;

    // new bits where mask is one, old bits elsewhere
    function automatic logic [`CSR_DATA_W-1:0] masked_merge(
        input logic [`CSR_DATA_W-1:0] old_val,
        input logic [`CSR_DATA_W-1:0] mask,
        input logic [`CSR_DATA_W-1:0] new_val
    );
        return (new_val & mask) | (old_val & ~mask);
    endfunction

endpackage

//--- hdl/csr_addr_decode.sv
`include "csr_macros.svh"

module csr_addr_decode (
    input  logic [`CSR_NUM_W-1:0] csr_num,
    input  csr_pkg::csr_wr_t      csr_wr,
    output csr_pkg::csr_sel_t     sel,
    output csr_pkg::csr_sel_t     rd_sel
);

    // read selects, unknown numbers leave everything low
    always_comb begin
        rd_sel         = '0;
        rd_sel.crmd    = (csr_num == `CSR_CRMD);
        rd_sel.prmd    = (csr_num == `CSR_PRMD);
        rd_sel.ecfg    = (csr_num == `CSR_ECFG);
        rd_sel.estat   = (csr_num == `CSR_ESTAT);
        rd_sel.era     = (csr_num == `CSR_ERA);
        rd_sel.badv    = (csr_num == `CSR_BADV);
        rd_sel.eentry  = (csr_num == `CSR_EENTRY);
        rd_sel.save[0] = (csr_num == `CSR_SAVE0);
        rd_sel.save[1] = (csr_num == `CSR_SAVE1);
        rd_sel.save[2] = (csr_num == `CSR_SAVE2);
        rd_sel.save[3] = (csr_num == `CSR_SAVE3);
        rd_sel.tid     = (csr_num == `CSR_TID);
        rd_sel.tcfg    = (csr_num == `CSR_TCFG);
        rd_sel.tval    = (csr_num == `CSR_TVAL);
        rd_sel.ticlr   = (csr_num == `CSR_TICLR);
    end

    // write selects only exist in the strobe cycle
    always_comb begin
        if (csr_wr.we) begin
            sel = rd_sel;
        end else begin
            sel = '0;
        end
    end

endmodule

//--- hdl/csr_trap_regs.sv
`include "csr_macros.svh"

module csr_trap_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  csr_pkg::csr_sel_t        sel,
    input  csr_pkg::csr_wr_t         csr_wr,
    input  csr_pkg::csr_exc_t        exc,
    input  logic                     ertn,
    output csr_pkg::csr_trap_state_t trap_state
);

    csr_pkg::csr_trap_state_t state_q;
    csr_pkg::csr_trap_state_t state_d;

    // later assignments win, so the order below sets the priority
    always_comb begin
        logic [`CSR_DATA_W-1:0] estat_new;

        state_d   = state_q;
        estat_new = csr_pkg::masked_merge({{(`CSR_DATA_W-2){1'b0}}, state_q.estat_is},
                                          csr_wr.mask & `CSR_WMASK_ESTAT, csr_wr.value);

        // software writes
        if (sel.crmd) begin
            state_d.crmd = csr_pkg::masked_merge(state_q.crmd,
                                                 csr_wr.mask & `CSR_WMASK_CRMD, csr_wr.value);
        end
        if (sel.prmd) begin
            state_d.prmd = csr_pkg::masked_merge(state_q.prmd,
                                                 csr_wr.mask & `CSR_WMASK_PRMD, csr_wr.value);
        end
        if (sel.ecfg) begin
            state_d.ecfg = csr_pkg::masked_merge(state_q.ecfg,
                                                 csr_wr.mask & `CSR_WMASK_ECFG, csr_wr.value);
        end
        if (sel.estat) begin
            // only the two software interrupt bits
            state_d.estat_is = estat_new[1:0];
        end
        if (sel.era) begin
            state_d.era = csr_pkg::masked_merge(state_q.era,
                                                csr_wr.mask & `CSR_WMASK_FULL, csr_wr.value);
        end
        if (sel.eentry) begin
            state_d.eentry = csr_pkg::masked_merge(state_q.eentry,
                                                   csr_wr.mask & `CSR_WMASK_EENTRY,
                                                   csr_wr.value);
        end
        for (int i = 0; i < 4; i++) begin
            if (sel.save[i]) begin
                state_d.save[i] = csr_pkg::masked_merge(state_q.save[i],
                                                        csr_wr.mask & `CSR_WMASK_FULL,
                                                        csr_wr.value);
            end
        end
        if (sel.tid) begin
            state_d.tid = csr_pkg::masked_merge(state_q.tid,
                                                csr_wr.mask & `CSR_WMASK_FULL, csr_wr.value);
        end

        // return: PIE/PPLV back into IE/PLV
        if (ertn) begin
            state_d.crmd[2:0] = state_q.prmd[2:0];
        end

        // exception entry
        if (exc.valid) begin
            state_d.prmd[2:0]      = state_q.crmd[2:0];
            state_d.crmd[2:0]      = 3'b000;
            state_d.estat_ecode    = exc.ecode;
            state_d.estat_esubcode = exc.esubcode;
            state_d.era            = exc.pc;
            if (exc.ecode == `CSR_ECODE_ADE && exc.esubcode == '0) begin
                // fetch address error, the pc is the bad address
                state_d.badv = exc.pc;
            end else if (exc.ecode == `CSR_ECODE_ALE) begin
                state_d.badv = exc.vaddr;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= '0;
            state_q.crmd   <= `CSR_CRMD_RST;
            state_q.eentry <= `CSR_EENTRY_RST;
        end else begin
            state_q <= state_d;
        end
    end

    assign trap_state = state_q;

endmodule

//--- hdl/csr_timer.sv
`include "csr_macros.svh"

module csr_timer (
    input  logic                      clk,
    input  logic                      rst,
    input  csr_pkg::csr_sel_t         sel,
    input  csr_pkg::csr_wr_t          csr_wr,
    output csr_pkg::csr_timer_state_t timer_state
);

    csr_pkg::csr_timer_state_t state_q;
    csr_pkg::csr_timer_state_t state_d;

    always_comb begin
        logic [`CSR_DATA_W-1:0] tcfg_new;
        logic                   set_ti;
        logic                   clr_ti;

        state_d  = state_q;
        set_ti   = 1'b0;
        tcfg_new = csr_pkg::masked_merge(state_q.tcfg, csr_wr.mask & `CSR_WMASK_TCFG,
                                         csr_wr.value);
        clr_ti   = sel.ticlr & csr_wr.mask[0] & csr_wr.value[0];

        // count down while enabled
        if (state_q.tcfg[`CSR_TCFG_EN_BIT]) begin
            if (state_q.tval != '0) begin
                state_d.tval = state_q.tval - 1'b1;
                // 1 -> 0 raises the interrupt
                if (state_q.tval == `CSR_DATA_W'(1)) begin
                    set_ti = 1'b1;
                end
            end else if (state_q.tcfg[`CSR_TCFG_PERIODIC_BIT]) begin
                state_d.tval = {state_q.tcfg[`CSR_DATA_W-1:2], 2'b00};
            end
        end

        // config write restarts the counter
        if (sel.tcfg) begin
            state_d.tcfg = tcfg_new;
            if (tcfg_new[`CSR_TCFG_EN_BIT]) begin
                state_d.tval = {tcfg_new[`CSR_DATA_W-1:2], 2'b00};
                // zero initial value fires at once
                if (tcfg_new[`CSR_DATA_W-1:2] == '0) begin
                    set_ti = 1'b1;
                end
            end
        end

        // set beats a same-cycle clear
        state_d.ti = set_ti | (state_q.ti & ~clr_ti);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= '0;
        end else begin
            state_q <= state_d;
        end
    end

    assign timer_state = state_q;

endmodule

//--- hdl/csr_read_result.sv
`include "csr_macros.svh"

module csr_read_result (
    input  csr_pkg::csr_sel_t         rd_sel,
    input  csr_pkg::csr_trap_state_t  trap_state,
    input  csr_pkg::csr_timer_state_t timer_state,
    output logic [`CSR_DATA_W-1:0]    csr_rvalue,
    output logic                      has_int
);

    logic [`CSR_DATA_W-1:0] estat;
    logic [`CSR_DATA_W-1:0] save_rvalue;

    // hardware lines IS[9:2] are not modelled and read as zero
    always_comb begin
        estat                     = '0;
        estat[1:0]                = trap_state.estat_is;
        estat[`CSR_TIMER_IRQ_BIT] = timer_state.ti;
        estat[21:16]              = trap_state.estat_ecode;
        estat[30:22]              = trap_state.estat_esubcode;
    end

    always_comb begin
        save_rvalue = '0;
        for (int i = 0; i < 4; i++) begin
            save_rvalue = save_rvalue | ({`CSR_DATA_W{rd_sel.save[i]}} & trap_state.save[i]);
        end
    end

    // selects are one-hot, TICLR has no image and reads zero
    assign csr_rvalue = {`CSR_DATA_W{rd_sel.crmd}}   & trap_state.crmd
                      | {`CSR_DATA_W{rd_sel.prmd}}   & trap_state.prmd
                      | {`CSR_DATA_W{rd_sel.ecfg}}   & trap_state.ecfg
                      | {`CSR_DATA_W{rd_sel.estat}}  & estat
                      | {`CSR_DATA_W{rd_sel.era}}    & trap_state.era
                      | {`CSR_DATA_W{rd_sel.badv}}   & trap_state.badv
                      | {`CSR_DATA_W{rd_sel.eentry}} & trap_state.eentry
                      | save_rvalue
                      | {`CSR_DATA_W{rd_sel.tid}}    & trap_state.tid
                      | {`CSR_DATA_W{rd_sel.tcfg}}   & timer_state.tcfg
                      | {`CSR_DATA_W{rd_sel.tval}}   & timer_state.tval;

    // pending and locally enabled, gated by global IE
    assign has_int = trap_state.crmd[`CSR_CRMD_IE_BIT]
                   && ((estat[12:0] & trap_state.ecfg[12:0]) != 13'b0);

endmodule

//--- hdl/csr_top.sv
`include "csr_macros.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CSR_NUM_W-1:0]  csr_num,
    input  csr_pkg::csr_wr_t       csr_wr,
    input  csr_pkg::csr_exc_t      exc,
    input  logic                   ertn,
    output logic [`CSR_DATA_W-1:0] csr_rvalue,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic [`CSR_DATA_W-1:0] ex_era,
    output logic                   has_int
);

    csr_pkg::csr_sel_t         sel;
    csr_pkg::csr_sel_t         rd_sel;
    csr_pkg::csr_trap_state_t  trap_state;
    csr_pkg::csr_timer_state_t timer_state;

    csr_addr_decode u_addr_decode (
        .csr_num (csr_num),
        .csr_wr  (csr_wr),
        .sel     (sel),
        .rd_sel  (rd_sel)
    );

    csr_trap_regs u_trap_regs (
        .clk        (clk),
        .rst        (rst),
        .sel        (sel),
        .csr_wr     (csr_wr),
        .exc        (exc),
        .ertn       (ertn),
        .trap_state (trap_state)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .sel         (sel),
        .csr_wr      (csr_wr),
        .timer_state (timer_state)
    );

    csr_read_result u_read_result (
        .rd_sel      (rd_sel),
        .trap_state  (trap_state),
        .timer_state (timer_state),
        .csr_rvalue  (csr_rvalue),
        .has_int     (has_int)
    );

    // redirect targets for the fetch stage
    assign ex_entry = trap_state.eentry;
    assign ex_era   = trap_state.era;

endmodule

//--- verif/csr_tb_clk.sv
module csr_tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/csr_tb.sv
`include "csr_macros.svh"

module csr_tb;

    localparam logic [31:0] crmd_wmask   = 32'h0000_01ff;
    localparam logic [31:0] prmd_wmask   = 32'h0000_0007;
    localparam logic [31:0] ecfg_wmask   = 32'h0000_1bff;
    localparam logic [31:0] eentry_wmask = 32'hffff_ffc0;

    logic                   clk;
    logic                   rst;
    logic [`CSR_NUM_W-1:0]  csr_num;
    csr_pkg::csr_wr_t       csr_wr;
    csr_pkg::csr_exc_t      exc;
    logic                   ertn;
    logic [`CSR_DATA_W-1:0] csr_rvalue;
    logic [`CSR_DATA_W-1:0] ex_entry;
    logic [`CSR_DATA_W-1:0] ex_era;
    logic                   has_int;

    // shadow register images
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ecfg;
    logic [1:0]  m_is;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esubcode;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_tval;
    logic        m_ti;

    string       test_name;
    logic [13:0] impl_nums [15] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA,
                                   `CSR_BADV, `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1,
                                   `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG, `CSR_TVAL,
                                   `CSR_TICLR};
    logic [13:0] unimpl_nums [5] = '{14'h002, 14'h008, 14'h043, 14'h100, 14'h3fff};

    csr_tb_clk u_clk (
        .clk (clk),
        .rst (rst)
    );

    csr_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .csr_num    (csr_num),
        .csr_wr     (csr_wr),
        .exc        (exc),
        .ertn       (ertn),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .ex_era     (ex_era),
        .has_int    (has_int)
    );

    function automatic logic [31:0] merge_bits(input logic [31:0] old_v, input logic [31:0] m,
                                               input logic [31:0] new_v);
        return (old_v & ~m) | (new_v & m);
    endfunction

    function automatic logic [31:0] expected_estat();
        logic [31:0] v;
        v        = '0;
        v[1:0]   = m_is;
        v[11]    = m_ti;
        v[21:16] = m_ecode;
        v[30:22] = m_esubcode;
        return v;
    endfunction

    function automatic logic [31:0] expected_read(input logic [13:0] num);
        case (num)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return expected_estat();
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TID:    return m_tid;
            `CSR_TCFG:   return m_tcfg;
            `CSR_TVAL:   return m_tval;
            default:     return '0;
        endcase
    endfunction

    function automatic logic expected_has_int();
        return m_crmd[2] && ((expected_estat() & m_ecfg & 32'h1fff) != 0);
    endfunction

    // later NBAs win, so entry beats ertn beats a software write
    always @(posedge clk or posedge rst) begin
        logic [31:0] new_cfg;
        logic        set_ti;
        logic        clr_ti;
        if (rst) begin
            m_crmd     <= 32'h0000_0008;
            m_prmd     <= '0;
            m_ecfg     <= '0;
            m_is       <= '0;
            m_ecode    <= '0;
            m_esubcode <= '0;
            m_era      <= '0;
            m_badv     <= '0;
            m_eentry   <= 32'h1c00_8000;
            m_save     <= '{default: '0};
            m_tid      <= '0;
            m_tcfg     <= '0;
            m_tval     <= '0;
            m_ti       <= 1'b0;
        end else begin
            new_cfg = merge_bits(m_tcfg, csr_wr.mask, csr_wr.value);
            set_ti  = 1'b0;
            clr_ti  = csr_wr.we && csr_num == `CSR_TICLR && csr_wr.mask[0] && csr_wr.value[0];
            if (csr_wr.we) begin
                case (csr_num)
                    `CSR_CRMD:   m_crmd <= merge_bits(m_crmd, csr_wr.mask & crmd_wmask,
                                                      csr_wr.value);
                    `CSR_PRMD:   m_prmd <= merge_bits(m_prmd, csr_wr.mask & prmd_wmask,
                                                      csr_wr.value);
                    `CSR_ECFG:   m_ecfg <= merge_bits(m_ecfg, csr_wr.mask & ecfg_wmask,
                                                      csr_wr.value);
                    `CSR_ESTAT:  m_is <= (m_is & ~csr_wr.mask[1:0])
                                       | (csr_wr.value[1:0] & csr_wr.mask[1:0]);
                    `CSR_ERA:    m_era <= merge_bits(m_era, csr_wr.mask, csr_wr.value);
                    `CSR_EENTRY: m_eentry <= merge_bits(m_eentry, csr_wr.mask & eentry_wmask,
                                                        csr_wr.value);
                    `CSR_SAVE0:  m_save[0] <= merge_bits(m_save[0], csr_wr.mask, csr_wr.value);
                    `CSR_SAVE1:  m_save[1] <= merge_bits(m_save[1], csr_wr.mask, csr_wr.value);
                    `CSR_SAVE2:  m_save[2] <= merge_bits(m_save[2], csr_wr.mask, csr_wr.value);
                    `CSR_SAVE3:  m_save[3] <= merge_bits(m_save[3], csr_wr.mask, csr_wr.value);
                    `CSR_TID:    m_tid <= merge_bits(m_tid, csr_wr.mask, csr_wr.value);
                    default:     ;
                endcase
            end
            if (ertn) begin
                m_crmd[2:0] <= m_prmd[2:0];
            end
            if (exc.valid) begin
                m_prmd[2:0] <= m_crmd[2:0];
                m_crmd[2:0] <= 3'b000;
                m_ecode     <= exc.ecode;
                m_esubcode  <= exc.esubcode;
                m_era       <= exc.pc;
                if (exc.ecode == 6'd8 && exc.esubcode == 9'd0) begin
                    m_badv <= exc.pc;
                end else if (exc.ecode == 6'd9) begin
                    m_badv <= exc.vaddr;
                end
            end
            // timer counts on the old config and a config write overrides it
            if (m_tcfg[0] && m_tval != 0) begin
                m_tval <= m_tval - 32'd1;
                set_ti = (m_tval == 32'd1);
            end else if (m_tcfg[0] && m_tcfg[1]) begin
                m_tval <= {m_tcfg[31:2], 2'b00};
            end
            if (csr_wr.we && csr_num == `CSR_TCFG) begin
                m_tcfg <= new_cfg;
                if (new_cfg[0]) begin
                    m_tval <= {new_cfg[31:2], 2'b00};
                    set_ti = set_ti | (new_cfg[31:2] == 30'd0);
                end
            end
            m_ti <= set_ti | (m_ti & ~clr_ti);
        end
    end

    task automatic end_with_failure();
        $display("Regression failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s %s (csr %h) expected %h actual %h", test_name, what, csr_num, exp, act);
        end_with_failure();
    endtask

    task automatic give_up(input string msg);
        $display("Error in %s: %s", test_name, msg);
        end_with_failure();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else mismatch(what, exp, act);
    endtask

    // compare every output at the falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            assert (csr_rvalue == expected_read(csr_num))
                else mismatch("csr_rvalue", expected_read(csr_num), csr_rvalue);
            assert (ex_entry == m_eentry) else mismatch("ex_entry", m_eentry, ex_entry);
            assert (ex_era == m_era) else mismatch("ex_era", m_era, ex_era);
            assert (has_int == expected_has_int())
                else mismatch("has_int", 32'(expected_has_int()), 32'(has_int));
        end
    end

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(posedge clk);
        csr_num <= num;
        csr_wr  <= '{we: 1'b1, mask: mask, value: value};
        @(posedge clk);
        csr_wr.we <= 1'b0;
    endtask

    task automatic select_csr(input logic [13:0] num);
        @(posedge clk);
        csr_num <= num;
    endtask

    task automatic sweep_reads();
        foreach (impl_nums[i]) select_csr(impl_nums[i]);
        foreach (unimpl_nums[i]) select_csr(unimpl_nums[i]);
    endtask

    task automatic raise_exception(input logic [5:0] code, input logic [8:0] sub);
        @(posedge clk);
        exc <= '{valid: 1'b1, ecode: code, esubcode: sub, pc: $urandom, vaddr: $urandom};
        @(posedge clk);
        exc.valid <= 1'b0;
    endtask

    task automatic return_from_exception();
        @(posedge clk);
        ertn <= 1'b1;
        @(posedge clk);
        ertn <= 1'b0;
    endtask

    task automatic wait_for_tval_zero(input int limit);
        logic [31:0] prev;
        logic        found;
        select_csr(`CSR_TVAL);
        @(negedge clk);
        prev  = csr_rvalue;
        found = (prev == 0);
        for (int i = 0; i < limit && !found; i++) begin
            @(negedge clk);
            check_value("tval step", prev - 32'd1, csr_rvalue);
            prev  = csr_rvalue;
            found = (prev == 0);
        end
        if (!found) give_up("TVAL did not reach zero before the timeout");
    endtask

    task automatic wait_for_timer_flag(input int limit);
        logic found;
        select_csr(`CSR_ESTAT);
        found = 1'b0;
        for (int i = 0; i < limit && !found; i++) begin
            @(negedge clk);
            found = csr_rvalue[11];
        end
        if (!found) give_up("timer interrupt flag did not rise before the timeout");
    endtask

    initial begin
        csr_pkg::csr_exc_t e;
        csr_num   = '0;
        csr_wr    = '0;
        exc       = '0;
        ertn      = 1'b0;
        test_name = "reset_values";
        void'($urandom(32'h5ea9_5d01));
        for (int i = 0; i < 10 && rst !== 1'b0; i++) @(posedge clk);
        if (rst !== 1'b0) give_up("reset was never released");
        @(negedge clk);
        check_value("ex_entry after reset", 32'h1c00_8000, ex_entry);
        check_value("has_int after reset", 32'd0, 32'(has_int));
        sweep_reads();

        test_name = "masked_writes";
        repeat (3) foreach (impl_nums[i]) write_csr(impl_nums[i], $urandom, $urandom);
        sweep_reads();

        test_name = "exception_entry_return";
        for (int k = 0; k < 8; k++) begin
            write_csr(`CSR_CRMD, 32'h7, $urandom);
            case (k % 4)
                0: raise_exception(6'd8, 9'd0);
                1: raise_exception(6'd8, 9'd1);
                2: raise_exception(6'd9, 9'($urandom));
                default: raise_exception(6'($urandom_range(63)), 9'($urandom));
            endcase
            sweep_reads();
            return_from_exception();
            select_csr(`CSR_CRMD);
        end

        test_name = "one_shot_timer";
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        write_csr(`CSR_TCFG, '1, (32'd6 << 2) | 32'h1);
        wait_for_tval_zero(100);
        select_csr(`CSR_ESTAT);
        @(negedge clk);
        check_value("timer flag at zero", 32'd1, 32'(csr_rvalue[11]));
        repeat (4) select_csr(`CSR_TVAL);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        select_csr(`CSR_ESTAT);
        @(negedge clk);
        check_value("timer flag after clear", 32'd0, 32'(csr_rvalue[11]));
        // zero initial value fires at once
        write_csr(`CSR_TCFG, '1, 32'h1);
        select_csr(`CSR_ESTAT);
        @(negedge clk);
        check_value("flag on zero load", 32'd1, 32'(csr_rvalue[11]));
        write_csr(`CSR_TICLR, 32'h1, 32'h1);

        test_name = "periodic_timer";
        write_csr(`CSR_TCFG, '1, (32'd4 << 2) | 32'h3);
        wait_for_timer_flag(100);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        repeat (3) select_csr(`CSR_TVAL);
        wait_for_timer_flag(100);
        write_csr(`CSR_TCFG, '1, 32'h0);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);

        test_name = "interrupt_pending";
        write_csr(`CSR_ECFG, '1, 32'h0);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        write_csr(`CSR_ESTAT, 32'h3, 32'h1);
        @(negedge clk);
        check_value("has_int without LIE", 32'd0, 32'(has_int));
        write_csr(`CSR_ECFG, '1, 32'h1);
        @(negedge clk);
        check_value("has_int on IS0", 32'd1, 32'(has_int));
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        @(negedge clk);
        check_value("has_int with IE off", 32'd0, 32'(has_int));
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        write_csr(`CSR_ECFG, '1, 32'h800);
        write_csr(`CSR_TCFG, '1, (32'd2 << 2) | 32'h1);
        wait_for_timer_flag(50);
        check_value("has_int on timer", 32'd1, 32'(has_int));
        write_csr(`CSR_TICLR, 32'h1, 32'h1);

        // random mix of writes, entries and returns in the same cycles
        test_name = "random_mix";
        for (int k = 0; k < 300; k++) begin
            e.valid    = ($urandom_range(7) == 0);
            e.ecode    = $urandom_range(1) ? 6'(8 + $urandom_range(1)) : 6'($urandom_range(63));
            e.esubcode = $urandom_range(1) ? 9'd0 : 9'($urandom);
            e.pc       = $urandom;
            e.vaddr    = $urandom;
            @(posedge clk);
            csr_num <= ($urandom_range(9) == 0) ? unimpl_nums[$urandom_range(4)]
                                                : impl_nums[$urandom_range(14)];
            csr_wr  <= '{we: ($urandom_range(2) == 0), mask: $urandom, value: $urandom};
            exc     <= e;
            ertn    <= ($urandom_range(7) == 0);
        end
        @(posedge clk);
        csr_wr.we <= 1'b0;
        exc.valid <= 1'b0;
        ertn      <= 1'b0;
        sweep_reads();
        @(negedge clk);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_addr_decode.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_read_result.sv
hdl/csr_top.sv
verif/csr_tb_clk.sv
verif/csr_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing -Wno-fatal --Mdir obj_dir
TOP   := csr_tb
FLIST := flist.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
